// ==== design/lane_pkg.sv ====
package lane_pkg;

   //////////////////////////////////////////////////
   // Lane defaults
   //////////////////////////////////////////////////
   localparam int VRF_DEPTH      = 64;
   localparam int VL_MAX         = 32;
   localparam int W_PORTS        = 2;
   // Operand 1 and operand 2 for every write port
   localparam int R_PORTS        = 2 * W_PORTS;
   localparam int BYTES_PER_WORD = 4;

   typedef logic [8*BYTES_PER_WORD-1:0] word_t;

   // SEW_NONE gives a zero operand
   typedef enum logic [1:0] {
      SEW_8    = 2'd0,
      SEW_16   = 2'd1,
      SEW_32   = 2'd2,
      SEW_NONE = 2'd3
   } sew_e;

   typedef enum logic [2:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLL,
      OP_MSEQ,
      OP_MSLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      OP2_VEC    = 2'd0,
      OP2_SCALAR = 2'd1,
      OP2_IMM    = 2'd2,
      OP2_ZERO   = 2'd3
   } op2_sel_e;

   // ALU controls, carried alongside the operand reads
   typedef struct packed {
      alu_op_e    op;
      op2_sel_e   op2_sel;
      word_t      scalar;
      logic [4:0] imm;
      logic       valid;
   } alu_ctrl_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
   parameter int DEPTH    = 64,
   parameter int WIDTH    = 32,
   parameter int LANES    = 4,
   parameter int RD_PORTS = 2,
   parameter int WR_PORTS = 1
) (
   input  logic                                     clk_i,
   input  logic [RD_PORTS-1:0][$clog2(DEPTH)-1:0]   raddr_i,
   output logic [RD_PORTS-1:0][WIDTH-1:0]           rdata_o,
   input  logic [WR_PORTS-1:0][$clog2(DEPTH)-1:0]   waddr_i,
   input  logic [WR_PORTS-1:0][WIDTH-1:0]           wdata_i,
   input  logic [WR_PORTS-1:0][LANES-1:0]           wbe_i
);

   localparam int LANE_W = WIDTH / LANES;

   logic [LANES-1:0][LANE_W-1:0] mem [DEPTH];

   //////////////////////////////////////////////////
   // Write ports
   //////////////////////////////////////////////////
   // Later ports overwrite earlier ones on an address clash
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < WR_PORTS; w++) begin
         for (int l = 0; l < LANES; l++) begin
            if (wbe_i[w][l]) begin
               mem[waddr_i[w]][l] <= wdata_i[w][l*LANE_W +: LANE_W];
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Registered reads, old data on a same-cycle write
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      for (int r = 0; r < RD_PORTS; r++) begin
         rdata_o[r] <= mem[raddr_i[r]];
      end
   end

endmodule

// ==== design/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
   parameter int  DEPTH     = 1,
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  payload_t d_i,
   output payload_t q_o
);

   payload_t stages [DEPTH];

   // Stage 0 takes the input, the last stage drives the output
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            stages[i] <= payload_t'('0);
         end
      end else begin
         stages[0] <= d_i;
         for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];
         end
      end
   end

   assign q_o = stages[DEPTH-1];

endmodule

// ==== design/element_extract.sv ====
`timescale 1ns/1ps

module element_extract (
   input  logic            clk_i,
   input  logic            rst_i,
   input  lane_pkg::word_t rdata_i,
   input  lane_pkg::sew_e  sew_i,
   input  logic [1:0]      el_idx_i,
   output lane_pkg::word_t elem_o
);

   import lane_pkg::*;

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   word_t       elem_d;

   // Byte and halfword muxes
   assign byte_sel = rdata_i[8*el_idx_i +: 8];
   assign half_sel = rdata_i[16*el_idx_i[0] +: 16];

   // Zero-extend the chosen element
   always_comb begin
      case (sew_i)
         SEW_8: begin
            elem_d = {24'd0, byte_sel};
         end
         SEW_16: begin
            elem_d = {16'd0, half_sel};
         end
         SEW_32: begin
            elem_d = rdata_i;
         end
         default: begin
            elem_d = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         elem_o <= '0;
      end else begin
         elem_o <= elem_d;
      end
   end

endmodule

// ==== design/lane_alu.sv ====
`timescale 1ns/1ps

module lane_alu (
   input  logic                clk_i,
   input  logic                rst_i,
   input  lane_pkg::word_t     op1_i,
   input  lane_pkg::word_t     op2v_i,
   input  lane_pkg::alu_ctrl_t ctrl_i,
   output lane_pkg::word_t     result_o,
   output logic                mask_o,
   output logic                valid_o
);

   import lane_pkg::*;

   word_t op2;
   word_t result_d;
   logic  mask_d;

   //////////////////////////////////////////////////
   // Operand 2 select
   //////////////////////////////////////////////////
   always_comb begin
      case (ctrl_i.op2_sel)
         OP2_VEC: begin
            op2 = op2v_i;
         end
         OP2_SCALAR: begin
            op2 = ctrl_i.scalar;
         end
         OP2_IMM: begin
            op2 = {27'd0, ctrl_i.imm};
         end
         default: begin
            op2 = '0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Operations
   //////////////////////////////////////////////////
   always_comb begin
      result_d = '0;
      mask_d   = 1'b0;
      case (ctrl_i.op)
         OP_ADD:   result_d = op1_i + op2;
         OP_SUB:   result_d = op1_i - op2;
         OP_AND:   result_d = op1_i & op2;
         OP_OR:    result_d = op1_i | op2;
         OP_XOR:   result_d = op1_i ^ op2;
         // Shift amount from the low five bits only
         OP_SLL:   result_d = op1_i << op2[4:0];
         // Compares leave the result at zero
         OP_MSEQ:  mask_d = (op1_i == op2);
         OP_MSLTU: mask_d = (op1_i < op2);
         default:  result_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= ctrl_i.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      result_o <= result_d;
      mask_o   <= mask_d;
   end

endmodule

// ==== design/write_back.sv ====
`timescale 1ns/1ps

module write_back #(
   parameter type wb_req_t,
   parameter int  VRF_AW  = 6,
   parameter int  VMRF_AW = 5
) (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  wb_req_t                             req_i,
   input  logic                                vm_bit_i,
   input  lane_pkg::word_t                     result_i,
   input  logic                                mask_i,
   input  logic                                valid_i,
   output logic [VRF_AW-1:0]                   vrf_waddr_o,
   output lane_pkg::word_t                     vrf_wdata_o,
   output logic [lane_pkg::BYTES_PER_WORD-1:0] vrf_wbe_o,
   output logic [VMRF_AW-1:0]                  vmrf_waddr_o,
   output logic                                vmrf_wdata_o,
   output logic                                vmrf_wen_o
);

   import lane_pkg::*;

   wb_req_t                   req_q;
   logic                      vm_bit_q;
   logic                      wr_ok;
   logic [BYTES_PER_WORD-1:0] be_masked;

   // Request waits for the ALU, three cycles after issue
   delay_line #(.DEPTH(3), .payload_t(wb_req_t)) req_dl (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (req_i),
      .q_o   (req_q)
   );

   // Mask bit leaves the VMRF at cycle 1
   delay_line #(.DEPTH(2), .payload_t(logic)) vm_dl (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (vm_bit_i),
      .q_o   (vm_bit_q)
   );

   assign wr_ok     = valid_i & req_q.valid;
   assign be_masked = req_q.vm ? (req_q.bwen & {BYTES_PER_WORD{vm_bit_q}}) : req_q.bwen;

   // VRF write
   assign vrf_waddr_o = req_q.vrf_addr;
   assign vrf_wdata_o = result_i;
   assign vrf_wbe_o   = be_masked & {BYTES_PER_WORD{wr_ok}};

   // VMRF write of the compare bit
   assign vmrf_waddr_o = req_q.vmrf_addr;
   assign vmrf_wdata_o = mask_i;
   assign vmrf_wen_o   = req_q.vmrf_wen & wr_ok;

endmodule

// ==== design/vector_lane.sv ====
`timescale 1ns/1ps

module vector_lane #(
   parameter int  VRF_DEPTH = lane_pkg::VRF_DEPTH,
   parameter int  VL_MAX    = lane_pkg::VL_MAX,
   parameter int  W_PORTS   = lane_pkg::W_PORTS,
   localparam int R_PORTS   = 2 * W_PORTS,
   localparam int VRF_AW    = $clog2(VRF_DEPTH),
   localparam int VMRF_AW   = $clog2(VL_MAX)
) (
   input  logic                                               clk_i,
   input  logic                                               rst_i,
   input  lane_pkg::sew_e                                     sew_i,
   input  logic [R_PORTS-1:0][VRF_AW-1:0]                     raddr_i,
   input  logic [R_PORTS-1:0][1:0]                            el_idx_i,
   input  logic [W_PORTS-1:0]                                 valid_i,
   input  lane_pkg::alu_op_e [W_PORTS-1:0]                    alu_op_i,
   input  lane_pkg::op2_sel_e [W_PORTS-1:0]                   op2_sel_i,
   input  lane_pkg::word_t [W_PORTS-1:0]                      scalar_i,
   input  logic [W_PORTS-1:0][4:0]                            imm_i,
   input  logic [W_PORTS-1:0][VRF_AW-1:0]                     waddr_i,
   input  logic [W_PORTS-1:0][lane_pkg::BYTES_PER_WORD-1:0]   bwen_i,
   input  logic [W_PORTS-1:0]                                 vm_i,
   input  logic [W_PORTS-1:0][VMRF_AW-1:0]                    vmrf_addr_i,
   input  logic [W_PORTS-1:0]                                 vmrf_wen_i,
   output lane_pkg::word_t [W_PORTS-1:0]                      alu_result_o,
   output logic [W_PORTS-1:0]                                 alu_mask_o,
   output logic [W_PORTS-1:0]                                 alu_valid_o
);

   import lane_pkg::*;

   typedef struct packed {
      logic [VRF_AW-1:0]         vrf_addr;
      logic [BYTES_PER_WORD-1:0] bwen;
      logic                      vm;
      logic [VMRF_AW-1:0]        vmrf_addr;
      logic                      vmrf_wen;
      logic                      valid;
   } wb_req_t;

   word_t [R_PORTS-1:0]                      vrf_rdata;
   word_t [R_PORTS-1:0]                      elem;
   logic  [R_PORTS-1:0][1:0]                 el_idx_q;
   sew_e                                     sew_q;
   alu_ctrl_t [W_PORTS-1:0]                  ctrl_d;
   alu_ctrl_t [W_PORTS-1:0]                  ctrl_q;
   wb_req_t [W_PORTS-1:0]                    wb_req;
   logic [W_PORTS-1:0][VRF_AW-1:0]           vrf_waddr;
   word_t [W_PORTS-1:0]                      vrf_wdata;
   logic [W_PORTS-1:0][BYTES_PER_WORD-1:0]   vrf_wbe;
   logic [W_PORTS-1:0]                       vmrf_rdata;
   logic [W_PORTS-1:0][VMRF_AW-1:0]          vmrf_waddr;
   logic [W_PORTS-1:0]                       vmrf_wdata;
   logic [W_PORTS-1:0]                       vmrf_wen;

   //////////////////////////////////////////////////
   // Register files
   //////////////////////////////////////////////////
   reg_file #(
      .DEPTH    (VRF_DEPTH),
      .WIDTH    ($bits(word_t)),
      .LANES    (BYTES_PER_WORD),
      .RD_PORTS (R_PORTS),
      .WR_PORTS (W_PORTS)
   ) vrf0 (
      .clk_i   (clk_i),
      .raddr_i (raddr_i),
      .rdata_o (vrf_rdata),
      .waddr_i (vrf_waddr),
      .wdata_i (vrf_wdata),
      .wbe_i   (vrf_wbe)
   );

   // One mask bit per element, read port per write port
   reg_file #(
      .DEPTH    (VL_MAX),
      .WIDTH    (1),
      .LANES    (1),
      .RD_PORTS (W_PORTS),
      .WR_PORTS (W_PORTS)
   ) vmrf0 (
      .clk_i   (clk_i),
      .raddr_i (vmrf_addr_i),
      .rdata_o (vmrf_rdata),
      .waddr_i (vmrf_waddr),
      .wdata_i (vmrf_wdata),
      .wbe_i   (vmrf_wen)
   );

   // SEW lines up with the read data at cycle 1
   delay_line #(.DEPTH(1), .payload_t(sew_e)) sew_dl (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .d_i   (sew_i),
      .q_o   (sew_q)
   );

   //////////////////////////////////////////////////
   // Per read port extraction
   //////////////////////////////////////////////////
   for (genvar r = 0; r < R_PORTS; r++) begin : g_rd
      delay_line #(.DEPTH(1), .payload_t(logic [1:0])) idx_dl (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .d_i   (el_idx_i[r]),
         .q_o   (el_idx_q[r])
      );

      element_extract extract0 (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .rdata_i  (vrf_rdata[r]),
         .sew_i    (sew_q),
         .el_idx_i (el_idx_q[r]),
         .elem_o   (elem[r])
      );
   end

   //////////////////////////////////////////////////
   // Per write port ALU and write-back
   //////////////////////////////////////////////////
   for (genvar p = 0; p < W_PORTS; p++) begin : g_wr
      assign ctrl_d[p].op      = alu_op_i[p];
      assign ctrl_d[p].op2_sel = op2_sel_i[p];
      assign ctrl_d[p].scalar  = scalar_i[p];
      assign ctrl_d[p].imm     = imm_i[p];
      assign ctrl_d[p].valid   = valid_i[p];

      assign wb_req[p].vrf_addr  = waddr_i[p];
      assign wb_req[p].bwen      = bwen_i[p];
      assign wb_req[p].vm        = vm_i[p];
      assign wb_req[p].vmrf_addr = vmrf_addr_i[p];
      assign wb_req[p].vmrf_wen  = vmrf_wen_i[p];
      assign wb_req[p].valid     = valid_i[p];

      // Controls meet the extracted operands at cycle 2
      delay_line #(.DEPTH(2), .payload_t(alu_ctrl_t)) ctrl_dl (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .d_i   (ctrl_d[p]),
         .q_o   (ctrl_q[p])
      );

      lane_alu alu0 (
         .clk_i    (clk_i),
         .rst_i    (rst_i),
         .op1_i    (elem[2*p]),
         .op2v_i   (elem[2*p+1]),
         .ctrl_i   (ctrl_q[p]),
         .result_o (alu_result_o[p]),
         .mask_o   (alu_mask_o[p]),
         .valid_o  (alu_valid_o[p])
      );

      write_back #(
         .wb_req_t (wb_req_t),
         .VRF_AW   (VRF_AW),
         .VMRF_AW  (VMRF_AW)
      ) wb0 (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .req_i        (wb_req[p]),
         .vm_bit_i     (vmrf_rdata[p]),
         .result_i     (alu_result_o[p]),
         .mask_i       (alu_mask_o[p]),
         .valid_i      (alu_valid_o[p]),
         .vrf_waddr_o  (vrf_waddr[p]),
         .vrf_wdata_o  (vrf_wdata[p]),
         .vrf_wbe_o    (vrf_wbe[p]),
         .vmrf_waddr_o (vmrf_waddr[p]),
         .vmrf_wdata_o (vmrf_wdata[p]),
         .vmrf_wen_o   (vmrf_wen[p])
      );
   end

endmodule

// ==== tb/lane_ref.svh ====
// Reference model functions for the lane

// Zero-extended element of a read word
function automatic word_t extract_elem(input word_t w, input sew_e sew, input logic [1:0] idx);
   case (sew)
      SEW_8:   return (w >> (8 * idx)) & 32'h0000_00ff;
      SEW_16:  return (w >> (16 * idx[0])) & 32'h0000_ffff;
      SEW_32:  return w;
      default: return '0;
   endcase
endfunction

// Operand 2 source
function automatic word_t pick_op2(input op2_sel_e sel, input word_t vec, input word_t scalar,
                                   input logic [4:0] imm);
   case (sel)
      OP2_VEC:    return vec;
      OP2_SCALAR: return scalar;
      OP2_IMM:    return word_t'(imm);
      default:    return '0;
   endcase
endfunction

// Mask bit on top of the 32-bit result
function automatic logic [32:0] alu_model(input alu_op_e op, input word_t a, input word_t b);
   case (op)
      OP_ADD:   return {1'b0, a + b};
      OP_SUB:   return {1'b0, a - b};
      OP_AND:   return {1'b0, a & b};
      OP_OR:    return {1'b0, a | b};
      OP_XOR:   return {1'b0, a ^ b};
      OP_SLL:   return {1'b0, a << b[4:0]};
      OP_MSEQ:  return {a == b, 32'd0};
      default:  return {a < b, 32'd0};
   endcase
endfunction

// Byte enables after masking
function automatic logic [BYTES_PER_WORD-1:0] masked_be(input logic [BYTES_PER_WORD-1:0] bwen,
                                                        input logic vm, input logic mbit);
   if (vm) begin
      return bwen & {BYTES_PER_WORD{mbit}};
   end
   return bwen;
endfunction

// Word after a byte-enabled write
function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                      input logic [BYTES_PER_WORD-1:0] be);
   word_t w;
   w = old_w;
   for (int b = 0; b < BYTES_PER_WORD; b++) begin
      if (be[b]) begin
         w[8*b +: 8] = new_w[8*b +: 8];
      end
   end
   return w;
endfunction

// ==== tb/tb_vector_lane.sv ====
`timescale 1ns/1ps

module tb_vector_lane;

   import lane_pkg::*;

   `include "lane_ref.svh"

   localparam int AW          = $clog2(VRF_DEPTH);
   localparam int MW          = $clog2(VL_MAX);
   localparam int PIPE_CYCLES = 200;
   // All phases take under 500 cycles
   localparam int TIMEOUT_CYCLES = 5000;

   // One issued operation
   typedef struct {
      logic [AW-1:0]             ra1;
      logic [AW-1:0]             ra2;
      logic [1:0]                idx1;
      logic [1:0]                idx2;
      alu_op_e                   op;
      op2_sel_e                  sel;
      word_t                     scalar;
      logic [4:0]                imm;
      logic [AW-1:0]             waddr;
      logic [BYTES_PER_WORD-1:0] bwen;
      logic                      vm;
      logic [MW-1:0]             vaddr;
      logic                      vwen;
   } op_t;

   // Expected outcome 3 cycles after issue
   typedef struct {
      string                     name;
      int                        cycle;
      word_t                     result;
      logic                      mask;
      logic [AW-1:0]             waddr;
      logic [BYTES_PER_WORD-1:0] be;
      logic [MW-1:0]             vaddr;
      logic                      vwen;
   } exp_t;

   logic                                  clk_i;
   logic                                  rst_i;
   sew_e                                  sew_i;
   logic [R_PORTS-1:0][AW-1:0]            raddr_i;
   logic [R_PORTS-1:0][1:0]               el_idx_i;
   logic [W_PORTS-1:0]                    valid_i;
   alu_op_e [W_PORTS-1:0]                 alu_op_i;
   op2_sel_e [W_PORTS-1:0]                op2_sel_i;
   word_t [W_PORTS-1:0]                   scalar_i;
   logic [W_PORTS-1:0][4:0]               imm_i;
   logic [W_PORTS-1:0][AW-1:0]            waddr_i;
   logic [W_PORTS-1:0][BYTES_PER_WORD-1:0] bwen_i;
   logic [W_PORTS-1:0]                    vm_i;
   logic [W_PORTS-1:0][MW-1:0]            vmrf_addr_i;
   logic [W_PORTS-1:0]                    vmrf_wen_i;
   word_t [W_PORTS-1:0]                   alu_result_o;
   logic [W_PORTS-1:0]                    alu_mask_o;
   logic [W_PORTS-1:0]                    alu_valid_o;

   word_t vrf_sh [VRF_DEPTH];
   logic  vmrf_sh [VL_MAX];
   exp_t  exp_q [W_PORTS][$];
   int    cycle = 0;

   vector_lane dut0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .sew_i        (sew_i),
      .raddr_i      (raddr_i),
      .el_idx_i     (el_idx_i),
      .valid_i      (valid_i),
      .alu_op_i     (alu_op_i),
      .op2_sel_i    (op2_sel_i),
      .scalar_i     (scalar_i),
      .imm_i        (imm_i),
      .waddr_i      (waddr_i),
      .bwen_i       (bwen_i),
      .vm_i         (vm_i),
      .vmrf_addr_i  (vmrf_addr_i),
      .vmrf_wen_i   (vmrf_wen_i),
      .alu_result_o (alu_result_o),
      .alu_mask_o   (alu_mask_o),
      .alu_valid_o  (alu_valid_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   always @(posedge clk_i) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Timeout, run still going after %0d cycles", cycle));
      end
   end

   // Plain read of ra through the ALU without a write
   function automatic op_t read_op(input logic [AW-1:0] ra);
      op_t o;
      o.ra1    = ra;
      o.ra2    = ra;
      o.idx1   = 2'd0;
      o.idx2   = 2'd0;
      o.op     = OP_ADD;
      o.sel    = OP2_IMM;
      o.scalar = '0;
      o.imm    = '0;
      o.waddr  = '0;
      o.bwen   = '0;
      o.vm     = 1'b0;
      o.vaddr  = '0;
      o.vwen   = 1'b0;
      return o;
   endfunction

   // Reads from the lower half, writes to the upper half
   function automatic op_t random_op();
      op_t o;
      o.ra1    = AW'($urandom_range(0, VRF_DEPTH/2 - 1));
      o.ra2    = AW'($urandom_range(0, VRF_DEPTH/2 - 1));
      o.idx1   = 2'($urandom_range(0, 3));
      o.idx2   = 2'($urandom_range(0, 3));
      o.op     = alu_op_e'($urandom_range(0, 7));
      o.sel    = op2_sel_e'($urandom_range(0, 3));
      o.scalar = $urandom();
      o.imm    = 5'($urandom_range(0, 31));
      o.waddr  = AW'($urandom_range(VRF_DEPTH/2, VRF_DEPTH - 1));
      o.bwen   = BYTES_PER_WORD'($urandom_range(0, 15));
      o.vm     = 1'($urandom_range(0, 1));
      o.vaddr  = MW'($urandom_range(0, VL_MAX - 1));
      o.vwen   = 1'($urandom_range(0, 1));
      return o;
   endfunction

   // Drives port p and queues the expected outcome
   task automatic issue(input int p, input string name, input op_t o);
      exp_t        e;
      word_t       a;
      word_t       b;
      logic [32:0] res;
      raddr_i[2*p]     = o.ra1;
      raddr_i[2*p+1]   = o.ra2;
      el_idx_i[2*p]    = o.idx1;
      el_idx_i[2*p+1]  = o.idx2;
      valid_i[p]       = 1'b1;
      alu_op_i[p]      = o.op;
      op2_sel_i[p]     = o.sel;
      scalar_i[p]      = o.scalar;
      imm_i[p]         = o.imm;
      waddr_i[p]       = o.waddr;
      bwen_i[p]        = o.bwen;
      vm_i[p]          = o.vm;
      vmrf_addr_i[p]   = o.vaddr;
      vmrf_wen_i[p]    = o.vwen;
      a        = extract_elem(vrf_sh[o.ra1], sew_i, o.idx1);
      b        = pick_op2(o.sel, extract_elem(vrf_sh[o.ra2], sew_i, o.idx2), o.scalar, o.imm);
      res      = alu_model(o.op, a, b);
      e.name   = name;
      e.cycle  = cycle;
      e.result = res[31:0];
      e.mask   = res[32];
      e.waddr  = o.waddr;
      e.be     = masked_be(o.bwen, o.vm, vmrf_sh[o.vaddr]);
      e.vaddr  = o.vaddr;
      e.vwen   = o.vwen;
      exp_q[p].push_back(e);
   endtask

   task automatic next_cycle();
      @(posedge clk_i);
      #10;
      valid_i = '0;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   //////////////////////////////////////////////////
   // Compare process
   //////////////////////////////////////////////////
   // Shadow write lands just before the edge that commits it
   task automatic commit(input exp_t e);
      vrf_sh[e.waddr] = merge_bytes(vrf_sh[e.waddr], e.result, e.be);
      if (e.vwen) begin
         vmrf_sh[e.vaddr] = e.mask;
      end
   endtask

   task automatic check_port(input int p);
      exp_t e;
      if (exp_q[p].size() > 0 && exp_q[p][0].cycle + 3 == cycle) begin
         e = exp_q[p].pop_front();
         assert (alu_valid_o[p] === 1'b1)
            else fail_run($sformatf("No valid on port %0d for %s, 3 cycles after issue",
                                    p, e.name));
         assert (alu_result_o[p] === e.result)
            else fail_run($sformatf("Mismatch %s port %0d result: expected %h, actual %h",
                                    e.name, p, e.result, alu_result_o[p]));
         assert (alu_mask_o[p] === e.mask)
            else fail_run($sformatf("Mismatch %s port %0d mask: expected %b, actual %b",
                                    e.name, p, e.mask, alu_mask_o[p]));
         commit(e);
      end else begin
         assert (alu_valid_o[p] === 1'b0)
            else fail_run($sformatf("Valid on port %0d in cycle %0d with nothing issued",
                                    p, cycle));
      end
   endtask

   always @(negedge clk_i) begin
      if (rst_i === 1'b1) begin
         for (int p = 0; p < W_PORTS; p++) begin
            check_port(p);
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   initial begin
      op_t o;
      void'($urandom(50));
      rst_i       = 1'b0;
      sew_i       = SEW_NONE;
      raddr_i     = '0;
      el_idx_i    = '0;
      valid_i     = '0;
      alu_op_i    = {W_PORTS{OP_ADD}};
      op2_sel_i   = {W_PORTS{OP2_VEC}};
      scalar_i    = '0;
      imm_i       = '0;
      waddr_i     = '0;
      bwen_i      = '0;
      vm_i        = '0;
      vmrf_addr_i = '0;
      vmrf_wen_i  = '0;
      repeat (3) @(posedge clk_i);
      #10;
      rst_i = 1'b1;

      // Fill VRF with scalars, VMRF with zeros from port 0
      sew_i = SEW_NONE;
      for (int a = 0; a < VRF_DEPTH; a += 2) begin
         for (int p = 0; p < W_PORTS; p++) begin
            o        = read_op('0);
            o.sel    = OP2_SCALAR;
            o.scalar = $urandom();
            o.waddr  = AW'(a + p);
            o.bwen   = '1;
            o.vaddr  = MW'((a / 2) % VL_MAX);
            o.vwen   = (p == 0);
            issue(p, "init", o);
         end
         next_cycle();
      end
      idle(4);
      sew_i = SEW_32;
      for (int a = 0; a < VRF_DEPTH; a += 2) begin
         issue(0, "readback", read_op(AW'(a)));
         issue(1, "readback", read_op(AW'(a + 1)));
         next_cycle();
      end

      // Every element index at byte and halfword width
      for (int a = 0; a < 4; a++) begin
         for (int s = 0; s < 2; s++) begin
            for (int idx = 0; idx < 4; idx++) begin
               sew_i  = sew_e'(s);
               o      = read_op(AW'(a));
               o.op   = OP_OR;
               o.idx1 = 2'(idx);
               issue(0, "extract", o);
               o.ra1  = AW'(a + 4);
               o.idx1 = 2'(3 - idx);
               issue(1, "extract", o);
               next_cycle();
            end
         end
      end

      // All operations with every operand 2 source
      sew_i = SEW_32;
      for (int rep = 0; rep < 3; rep++) begin
         for (int op = 0; op < 8; op++) begin
            for (int sel = 0; sel < 3; sel++) begin
               for (int p = 0; p < W_PORTS; p++) begin
                  o     = random_op();
                  o.op  = alu_op_e'(op);
                  o.sel = op2_sel_e'(sel);
                  o.vm  = 1'b0;
                  // Equal operands so the compares also see a match
                  if (rep == 0) begin
                     o.ra2 = o.ra1;
                  end
                  issue(p, "alu", o);
               end
               next_cycle();
            end
         end
      end
      idle(4);

      // Partial byte writes read back 4 cycles after each write
      for (int be = 1; be < 15; be++) begin
         sew_i    = SEW_NONE;
         o        = read_op('0);
         o.sel    = OP2_SCALAR;
         o.scalar = $urandom();
         o.waddr  = AW'(10);
         o.bwen   = BYTES_PER_WORD'(be);
         issue(0, "byte_en", o);
         next_cycle();
         idle(3);
         sew_i = SEW_32;
         issue(1, "byte_en", read_op(AW'(10)));
         next_cycle();
      end
      idle(4);

      // Mask bit 3 set by an equal compare, bit 4 cleared by an unsigned less-than zero
      sew_i  = SEW_32;
      o      = read_op(AW'(20));
      o.op   = OP_MSEQ;
      o.sel  = OP2_VEC;
      o.vaddr = MW'(3);
      o.vwen = 1'b1;
      issue(0, "mask_cmp", o);
      o      = read_op(AW'(20));
      o.op   = OP_MSLTU;
      o.vaddr = MW'(4);
      o.vwen = 1'b1;
      issue(1, "mask_cmp", o);
      next_cycle();
      idle(3);
      sew_i = SEW_NONE;
      for (int p = 0; p < W_PORTS; p++) begin
         o        = read_op('0);
         o.sel    = OP2_SCALAR;
         o.scalar = $urandom();
         o.waddr  = AW'(21 + p);
         o.bwen   = '1;
         o.vm     = 1'b1;
         o.vaddr  = MW'(3 + p);
         issue(p, "mask_write", o);
      end
      next_cycle();
      idle(3);
      sew_i = SEW_32;
      issue(0, "mask_readback", read_op(AW'(21)));
      issue(1, "mask_readback", read_op(AW'(22)));
      next_cycle();
      idle(4);

      // Back-to-back random traffic on both ports
      repeat (PIPE_CYCLES) begin
         sew_i = sew_e'($urandom_range(0, 2));
         issue(0, "pipeline", random_op());
         issue(1, "pipeline", random_op());
         next_cycle();
      end
      idle(5);

      $display("Everything OK");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+tb
design/lane_pkg.sv
design/reg_file.sv
design/delay_line.sv
design/element_extract.sv
design/lane_alu.sv
design/write_back.sv
design/vector_lane.sv
tb/tb_vector_lane.sv

// ==== Bender.yml ====
package:
  name: vector_lane

sources:
  - files:
      - design/lane_pkg.sv
      - design/reg_file.sv
      - design/delay_line.sv
      - design/element_extract.sv
      - design/lane_alu.sv
      - design/write_back.sv
      - design/vector_lane.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_vector_lane.sv
